// ==== Bender.yml ====
package:
  name: channel_agc

sources:
  - src/agcPkg.sv
  - src/agcMagnitude.sv
  - src/agcLog2.sv
  - src/agcRegisters.sv
  - src/agcLoopFilter.sv
  - src/channelAgc.sv
  - target: test
    files:
      - verification/channelAgc_props.sv
      - verification/channelAgcTb.sv

// ==== src.f ====
src/agcPkg.sv
src/agcMagnitude.sv
src/agcLog2.sv
src/agcRegisters.sv
src/agcLoopFilter.sv
src/channelAgc.sv
verification/channelAgc_props.sv
verification/channelAgcTb.sv

// ==== src/agcLog2.sv ====
`timescale 1ns/100ps
`default_nettype none

module agcLog2 (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            syncIn,
    input  wire agcPkg::level_t  level,
    output agcPkg::logMag_t      logMag
);

    import agcPkg::*;

    logic [3:0] leadPos;
    level_t     normalized;
    logic [3:0] mantissa;
    logMag_t    logNext;

    // Leading-one search
    // Scans upward so the highest set bit wins
    always_comb begin
        leadPos = '0;
        for (int bitIdx = 0; bitIdx < $bits(level_t); bitIdx++) begin
            if (level[bitIdx]) begin
                leadPos = 4'(bitIdx);
            end
        end
    end

    // Shift the leading one up to bit 15
    // Bits below a low leading one fill with zeros
    assign normalized = level << (4'd15 - leadPos);

    // Four bits right under the leading one
    assign mantissa = normalized[14:11];

    // Exponent in the upper nibble, linear mantissa below
    // A zero level lands on 0 without a special case
    assign logNext = {leadPos, mantissa};

    // One strobe stage
    always_ff @(posedge clk) begin
        if (reset) begin
            logMag <= '0;
        end else if (syncIn) begin
            logMag <= logNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/agcLoopFilter.sv ====
`timescale 1ns/100ps
`default_nettype none

module agcLoopFilter (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               syncIn,
    input  wire agcPkg::logMag_t    logMag,
    input  wire agcPkg::agcConfig_t loopConfig,
    input  wire logic               presetLoad,
    input  wire agcPkg::acc_t       presetValue,
    output agcPkg::acc_t            accumulator,
    output agcPkg::gain_t           agcGain
);

    import agcPkg::*;

    // Error shifted by up to 31 needs 40 bits
    // Two more leave room for the sum and its sign
    localparam int accWidth  = $bits(acc_t);
    localparam int stepWidth = accWidth + 10;

    levelErr_t                   levelErr;
    logic signed [stepWidth-1:0] step;
    logic signed [stepWidth-1:0] sum;
    logic                        underflow;
    logic                        overflow;
    acc_t                        accNext;

    // Positive error means the signal is below reference, so gain goes up
    assign levelErr = $signed({1'b0, loopConfig.refLevel}) - $signed({1'b0, logMag});

    // Sign-extend, then scale by the loop gain shift
    assign step = stepWidth'(levelErr) <<< loopConfig.loopShift;

    // Accumulator is unsigned, zero-extend before adding
    assign sum = $signed({{(stepWidth - accWidth){1'b0}}, accumulator}) + step;

    // Below zero or past all ones
    assign underflow = sum[stepWidth-1];
    assign overflow  = |sum[stepWidth-2:accWidth];

    // Clamp to the accumulator range
    always_comb begin
        if (underflow) begin
            accNext = '0;
        end else if (overflow) begin
            accNext = '1;
        end else begin
            accNext = sum[accWidth-1:0];
        end
    end

    // Integrator
    // Preset is not tied to the strobe and beats integration
    always_ff @(posedge clk) begin
        if (reset) begin
            accumulator <= '0;
        end else if (presetLoad) begin
            accumulator <= presetValue;
        end else if (syncIn && loopConfig.loopEnable) begin
            accumulator <= accNext;
        end
    end

    // Gain is the top 21 bits
    assign agcGain = accumulator[accWidth-1:GAIN_LSB];

endmodule

`default_nettype wire

// ==== src/agcMagnitude.sv ====
`timescale 1ns/100ps
`default_nettype none

module agcMagnitude #(
    parameter int sampleWidth = 18
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   syncIn,
    input  wire logic [sampleWidth-1:0] iIn,
    input  wire logic [sampleWidth-1:0] qIn,
    output agcPkg::level_t              level
);

    import agcPkg::*;

    // Weighted product before the shift by 18
    localparam int prodWidth = sampleWidth + $bits(weight_t);
    // Sum is at least one bit wider than the level so overflow is visible
    localparam int sumWidth = (sampleWidth + 1 > $bits(level_t) + 1) ?
                              sampleWidth + 1 : $bits(level_t) + 1;

    logic [sampleWidth-1:0] absI;
    logic [sampleWidth-1:0] absQ;
    logic [sampleWidth-1:0] maxMag;
    logic [sampleWidth-1:0] minMag;
    logic [prodWidth-1:0]   maxProd;
    logic [prodWidth-1:0]   minProd;
    logic [sampleWidth-1:0] maxTerm;
    logic [sampleWidth-1:0] minTerm;
    logic [sumWidth-1:0]    sum;
    logic                   overflow;

    // Absolute values
    // Negative full scale gives 2^(sampleWidth-1), which still fits unsigned
    assign absI = iIn[sampleWidth-1] ? (~iIn + 1'b1) : iIn;
    assign absQ = qIn[sampleWidth-1] ? (~qIn + 1'b1) : qIn;

    // Stage one, sort into max and min
    always_ff @(posedge clk) begin
        if (reset) begin
            maxMag <= '0;
            minMag <= '0;
        end else if (syncIn) begin
            if (absI > absQ) begin
                maxMag <= absI;
                minMag <= absQ;
            end else begin
                maxMag <= absQ;
                minMag <= absI;
            end
        end
    end

    // Constant weight products
    assign maxProd = maxMag * MAX_WEIGHT;
    assign minProd = minMag * MIN_WEIGHT;

    // Drop the 18 fraction bits of each term
    assign maxTerm = maxProd[prodWidth-1 -: sampleWidth];
    assign minTerm = minProd[prodWidth-1 -: sampleWidth];

    // Alpha * Max + Beta * Min
    assign sum = sumWidth'(maxTerm) + sumWidth'(minTerm);

    // Anything at or above 65536 saturates
    assign overflow = |sum[sumWidth-1:$bits(level_t)];

    // Stage two, saturated level
    always_ff @(posedge clk) begin
        if (reset) begin
            level <= '0;
        end else if (syncIn) begin
            if (overflow) begin
                level <= '1;
            end else begin
                level <= sum[$bits(level_t)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/agcPkg.sv ====
`default_nettype none

package agcPkg;

    // Linear level out of the magnitude estimator, 0 to 65535
    typedef logic [15:0] level_t;

    // Log level
    // Upper nibble is the leading-one position, lower nibble the next four bits
    typedef logic [7:0] logMag_t;

    // Gain word taken from the top of the loop accumulator
    typedef logic [20:0] gain_t;

    // Loop accumulator, unsigned and saturating
    typedef logic [31:0] acc_t;

    // Reference minus log, one bit wider than the log level
    typedef logic signed [8:0] levelErr_t;

    // Magnitude weights, scaled by 2^17
    typedef logic [17:0] weight_t;

    // Register bus
    typedef logic [12:0] regAddr_t;
    typedef logic [31:0] busWord_t;

    // Min peak error weights, 0.9604 and 0.3978
    localparam weight_t MAX_WEIGHT = 18'd125886;
    localparam weight_t MIN_WEIGHT = 18'd52144;

    // Lowest accumulator bit that reaches the gain word
    localparam int GAIN_LSB = 11;

    // Channel AGC register space
    localparam regAddr_t ADDR_CONFIG = 13'h0040;
    localparam regAddr_t ADDR_PRESET = 13'h0044;
    localparam regAddr_t ADDR_STATUS = 13'h0048;

    // Loop configuration
    // Config word layout is refLevel in byte 0, loopShift in byte 1, loopEnable in byte 2
    typedef struct packed {
        logMag_t    refLevel;
        logic [4:0] loopShift;
        logic       loopEnable;
    } agcConfig_t;

    // Current level and log level, read back through the status register
    typedef struct packed {
        level_t  level;
        logMag_t logMag;
    } agcStatus_t;

    localparam agcConfig_t CONFIG_RESET = '{refLevel: 8'hC0, loopShift: 5'd0, loopEnable: 1'b0};

endpackage

`default_nettype wire

// ==== src/agcRegisters.sv ====
`timescale 1ns/100ps
`default_nettype none

module agcRegisters (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               wr0,
    input  wire logic               wr1,
    input  wire logic               wr2,
    input  wire logic               wr3,
    input  wire agcPkg::regAddr_t   addr,
    input  wire agcPkg::busWord_t   din,
    input  wire agcPkg::agcStatus_t status,
    input  wire agcPkg::acc_t       accumulator,
    output agcPkg::busWord_t        dout,
    output agcPkg::agcConfig_t      loopConfig,
    output logic                    presetLoad,
    output agcPkg::acc_t            presetValue
);

    import agcPkg::*;

    logic configSel;
    logic presetSel;
    logic statusSel;

    // Address decode
    assign configSel = (addr == ADDR_CONFIG);
    assign presetSel = (addr == ADDR_PRESET);
    assign statusSel = (addr == ADDR_STATUS);

    // Configuration, one field per byte lane
    always_ff @(posedge clk) begin
        if (reset) begin
            loopConfig <= CONFIG_RESET;
        end else if (configSel) begin
            if (wr0) begin
                loopConfig.refLevel <= din[7:0];
            end
            if (wr1) begin
                loopConfig.loopShift <= din[12:8];
            end
            if (wr2) begin
                loopConfig.loopEnable <= din[16];
            end
        end
    end

    // Preset word built up byte by byte
    always_ff @(posedge clk) begin
        if (presetSel) begin
            if (wr0) begin
                presetValue[7:0] <= din[7:0];
            end
            if (wr1) begin
                presetValue[15:8] <= din[15:8];
            end
            if (wr2) begin
                presetValue[23:16] <= din[23:16];
            end
            if (wr3) begin
                presetValue[31:24] <= din[31:24];
            end
        end
    end

    // Byte 0 write fires the load, lined up with the assembled word
    always_ff @(posedge clk) begin
        if (reset) begin
            presetLoad <= 1'b0;
        end else begin
            presetLoad <= presetSel & wr0;
        end
    end

    // Read-back mux
    // Preset address returns the live accumulator
    always_comb begin
        dout = '0;
        if (configSel) begin
            dout[7:0]  = loopConfig.refLevel;
            dout[12:8] = loopConfig.loopShift;
            dout[16]   = loopConfig.loopEnable;
        end else if (presetSel) begin
            dout = accumulator;
        end else if (statusSel) begin
            dout = busWord_t'(status);
        end
    end

endmodule

`default_nettype wire

// ==== src/channelAgc.sv ====
`timescale 1ns/100ps
`default_nettype none

module channelAgc #(
    parameter int sampleWidth = 18
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   syncIn,
    input  wire logic                   wr0,
    input  wire logic                   wr1,
    input  wire logic                   wr2,
    input  wire logic                   wr3,
    input  wire agcPkg::regAddr_t       addr,
    input  wire agcPkg::busWord_t       din,
    input  wire logic [sampleWidth-1:0] iIn,
    input  wire logic [sampleWidth-1:0] qIn,
    output agcPkg::busWord_t            dout,
    output agcPkg::gain_t               agcGain
);

    import agcPkg::*;

    level_t     level;
    logMag_t    logMag;
    agcConfig_t loopConfig;
    agcStatus_t status;
    acc_t       accumulator;
    logic       presetLoad;
    acc_t       presetValue;

    // Linear level, two strobes after the sample
    agcMagnitude #(
        .sampleWidth(sampleWidth)
    ) magnitude_inst (
        .clk   (clk),
        .reset (reset),
        .syncIn(syncIn),
        .iIn   (iIn),
        .qIn   (qIn),
        .level (level)
    );

    // Log level, third strobe
    agcLog2 log2_inst (
        .clk   (clk),
        .reset (reset),
        .syncIn(syncIn),
        .level (level),
        .logMag(logMag)
    );

    // Status word for read-back
    assign status = '{level: level, logMag: logMag};

    agcRegisters registers_inst (
        .clk        (clk),
        .reset      (reset),
        .wr0        (wr0),
        .wr1        (wr1),
        .wr2        (wr2),
        .wr3        (wr3),
        .addr       (addr),
        .din        (din),
        .status     (status),
        .accumulator(accumulator),
        .dout       (dout),
        .loopConfig (loopConfig),
        .presetLoad (presetLoad),
        .presetValue(presetValue)
    );

    // Integrator, fourth strobe
    agcLoopFilter loopFilter_inst (
        .clk        (clk),
        .reset      (reset),
        .syncIn     (syncIn),
        .logMag     (logMag),
        .loopConfig (loopConfig),
        .presetLoad (presetLoad),
        .presetValue(presetValue),
        .accumulator(accumulator),
        .agcGain    (agcGain)
    );

endmodule

`default_nettype wire

// ==== verification/channelAgcTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module channelAgcTb;

    import agcPkg::*;

    localparam int sampleWidth = 18;
    // Longest wait for one strobe in clocks
    localparam int strobeTimeout = 20;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   syncIn = 1'b0;
    logic                   wr0 = 1'b0;
    logic                   wr1 = 1'b0;
    logic                   wr2 = 1'b0;
    logic                   wr3 = 1'b0;
    regAddr_t               addr = '0;
    busWord_t               din = '0;
    logic [sampleWidth-1:0] iIn = '0;
    logic [sampleWidth-1:0] qIn = '0;
    busWord_t               dout;
    gain_t                  agcGain;

    logic [1:0]  syncPhase = '0;
    logic [31:0] rngState = 32'd38;
    // Config word as the register map defines it
    // refLevel is 0xC0 out of reset
    busWord_t    expConfig = 32'h0000_00C0;
    logMag_t     heldLog;
    // Model accumulator, restarted by every preset write
    acc_t        modelAcc;
    int          errors = 0;
    int          timeouts = 0;

    channelAgc #(
        .sampleWidth(sampleWidth)
    ) channelAgc_inst (
        .clk    (clk),
        .reset  (reset),
        .syncIn (syncIn),
        .wr0    (wr0),
        .wr1    (wr1),
        .wr2    (wr2),
        .wr3    (wr3),
        .addr   (addr),
        .din    (din),
        .iIn    (iIn),
        .qIn    (qIn),
        .dout   (dout),
        .agcGain(agcGain)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // One-cycle strobe every fourth clock
    always @(posedge clk) begin
        syncPhase <= syncPhase + 2'd1;
        syncIn <= (syncPhase == 2'd3);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Alpha Max plus Beta Min
    // Weights 125886 and 52144 are scaled by 2^17 and each term is shifted by 18
    function automatic level_t modelLevel(input logic [17:0] i, input logic [17:0] q);
        longint ai;
        longint aq;
        longint sum;
        ai = longint'($signed(i));
        aq = longint'($signed(q));
        ai = (ai < 0) ? -ai : ai;
        aq = (aq < 0) ? -aq : aq;
        if (ai < aq) begin
            sum = ((aq * 125886) >>> 18) + ((ai * 52144) >>> 18);
        end else begin
            sum = ((ai * 125886) >>> 18) + ((aq * 52144) >>> 18);
        end
        return (sum > 65535) ? 16'hFFFF : level_t'(sum);
    endfunction

    // Leading-one position in the upper nibble and the next four bits below
    function automatic logMag_t modelLog(input level_t lvl);
        int         pos;
        logic [3:0] mant;
        if (lvl == 0) begin
            return '0;
        end
        pos = 15;
        while (!lvl[pos]) begin
            pos--;
        end
        if (pos >= 4) begin
            mant = 4'(lvl >> (pos - 4));
        end else begin
            mant = 4'(lvl << (4 - pos));
        end
        return {4'(pos), mant};
    endfunction

    // One enabled strobe of the loop clamped to the 32-bit range
    function automatic acc_t integrate(input acc_t acc, input busWord_t cfg, input logMag_t lg);
        longint next;
        if (!cfg[16]) begin
            return acc;
        end
        next = longint'(acc) + ((longint'(cfg[7:0]) - longint'(lg)) <<< cfg[12:8]);
        if (next < 0) begin
            return '0;
        end else if (next >= (longint'(1) <<< 32)) begin
            return '1;
        end
        return acc_t'(next);
    endfunction

    // Only the mapped config bits survive a byte write
    function automatic busWord_t mergeBytes(input busWord_t old, input busWord_t d,
                                            input logic [3:0] strobes);
        busWord_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strobes[b]) begin
                res[8*b +: 8] = d[8*b +: 8];
            end
        end
        return res & 32'h0001_1FFF;
    endfunction

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after the n-th strobe edge
    task automatic waitStrobes(input int n);
        int seen;
        int clocks;
        seen = 0;
        clocks = 0;
        while (seen < n && clocks < n * strobeTimeout) begin
            if (syncIn) begin
                seen++;
            end
            @(negedge clk);
            clocks++;
        end
        if (seen < n) begin
            timeouts++;
            $display("Timeout: syncIn did not pulse %0d times within %0d clocks", n, clocks);
        end
    endtask

    task automatic busWrite(input regAddr_t a, input busWord_t d, input logic [3:0] strobes);
        @(posedge clk);
        addr <= a;
        din <= d;
        {wr3, wr2, wr1, wr0} <= strobes;
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'b0000;
        @(negedge clk);
    endtask

    task automatic busRead(input regAddr_t a, output busWord_t d);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        d = dout;
    endtask

    task automatic configWrite(input busWord_t d, input logic [3:0] strobes);
        busWord_t rd;
        busWrite(ADDR_CONFIG, d, strobes);
        expConfig = mergeBytes(expConfig, d, strobes);
        busRead(ADDR_CONFIG, rd);
        checkEqual("config readback", expConfig, rd);
    endtask

    // Preset loads on the clock after the write whatever the strobe does
    task automatic presetWrite(input acc_t value);
        busWord_t rd;
        busWrite(ADDR_PRESET, value, 4'b1111);
        modelAcc = value;
        busRead(ADDR_PRESET, rd);
        checkEqual("preset accumulator", value, rd);
        checkEqual("preset gain", value >> 11, agcGain);
    endtask

    // Hold one sample past the three pipeline strobes and then check level and log
    task automatic checkHeldSample(input logic [17:0] i, input logic [17:0] q);
        busWord_t rd;
        level_t   lvl;
        @(posedge clk);
        iIn <= i;
        qIn <= q;
        @(negedge clk);
        waitStrobes(4);
        busRead(ADDR_STATUS, rd);
        lvl = modelLevel(i, q);
        heldLog = modelLog(lvl);
        checkEqual("status level", lvl, rd[23:8]);
        checkEqual("status log", heldLog, rd[7:0]);
    endtask

    // Steps the model accumulator one strobe at a time right after a preset write
    task automatic checkLoopSteps(input string name, input int n);
        busWord_t rd;
        repeat (n) begin
            waitStrobes(1);
            modelAcc = integrate(modelAcc, expConfig, heldLog);
            busRead(ADDR_PRESET, rd);
            checkEqual(name, modelAcc, rd);
            checkEqual({name, " gain"}, modelAcc >> 11, agcGain);
        end
    endtask

    initial begin
        busWord_t    rd;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [3:0]  shift;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Reset defaults
        checkEqual("reset gain", 0, agcGain);
        busRead(ADDR_CONFIG, rd);
        checkEqual("reset config", expConfig, rd);
        busRead(ADDR_STATUS, rd);
        checkEqual("reset status", 0, rd);

        // One byte lane at a time with the loop left disabled
        configWrite(32'hA5A5_1F33, 4'b0001);
        configWrite(32'hFFFF_0A00, 4'b0010);
        configWrite(32'h00FE_FFFF, 4'b0100);
        configWrite(32'hFFFF_FFFF, 4'b1000);
        busRead(13'h0100, rd);
        checkEqual("unmapped read", 0, rd);
        busRead(13'h004C, rd);
        checkEqual("unmapped read", 0, rd);

        // Corner samples at zero and both full scales
        checkHeldSample(18'h00000, 18'h00000);
        checkHeldSample(18'h1FFFF, 18'h1FFFF);
        checkHeldSample(18'h20000, 18'h20000);
        checkHeldSample(18'h20000, 18'h00000);
        checkHeldSample(18'h00003, 18'h3FFFE);
        repeat (12) begin
            rngState = xorshift(rngState);
            r1 = rngState;
            rngState = xorshift(rngState);
            r2 = rngState;
            // Same random right shift on both rails spreads the levels over all exponents
            shift = r1[31] ? 4'd0 : r1[30:27];
            checkHeldSample(18'(r1[17:0] >> shift), 18'(r2[17:0] >> shift));
        end

        // Preset holds while the loop is off
        presetWrite(32'h8000_0000);
        checkLoopSteps("preset hold", 2);

        // Below reference then above it
        configWrite(32'h0001_08C0, 4'b0111);
        checkHeldSample(18'h00100, 18'h00040);
        presetWrite(32'h8000_0000);
        checkLoopSteps("loop up", 6);
        checkHeldSample(18'h1FFFF, 18'h00000);
        presetWrite(32'h8000_0000);
        checkLoopSteps("loop down", 6);

        // Zero error
        configWrite({24'h0, heldLog}, 4'b0001);
        presetWrite(32'h4000_0000);
        checkLoopSteps("loop equal", 4);

        // Large shifts drive the accumulator into both clamps
        configWrite(32'h0001_1800, 4'b0111);
        presetWrite(32'h8000_0000);
        checkLoopSteps("clamp low", 3);
        configWrite(32'h0001_1FFF, 4'b0111);
        presetWrite(32'h4000_0000);
        checkLoopSteps("clamp high", 4);

        // Disabled loop freezes the gain
        configWrite(32'h0000_0000, 4'b0100);
        presetWrite(32'h1234_5678);
        checkLoopSteps("loop disabled", 4);

        $display("Check errors: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, channelAgc_inst.props_inst.failCount, timeouts);
        if (errors == 0 && timeouts == 0 && channelAgc_inst.props_inst.failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/channelAgc_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module channelAgc_props (
    input wire logic          clk,
    input wire logic          reset,
    input wire logic          syncIn,
    input wire logic          presetLoad,
    input wire agcPkg::gain_t agcGain
);

    // Assertion failures so far
    int failCount = 0;

    // Reset clears the gain
    resetClearsGain: assert property (@(posedge clk) reset |=> agcGain == '0)
        else begin
            failCount++;
            $error("agcGain is not zero after reset");
        end

    // Gain moves only on the clock after a strobe or a preset load
    gainHeldBetweenUpdates: assert property (@(posedge clk) disable iff (reset)
        (!syncIn && !presetLoad) |=> $stable(agcGain))
        else begin
            failCount++;
            $error("agcGain changed without syncIn or presetLoad");
        end

    // Preset load is a single-cycle pulse
    presetIsPulse: assert property (@(posedge clk) disable iff (reset)
        presetLoad |=> !presetLoad)
        else begin
            failCount++;
            $error("presetLoad stayed high for more than one cycle");
        end

endmodule

bind channelAgc channelAgc_props props_inst (
    .clk       (clk),
    .reset     (reset),
    .syncIn    (syncIn),
    .presetLoad(presetLoad),
    .agcGain   (agcGain)
);

`default_nettype wire
